// File: hw/actuatorControl.sv
`default_nettype none

module actuatorControl (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [homeCtrlPkg::wordWidth-1:0]        wbInstruction,
    input  logic [homeCtrlPkg::wordWidth-1:0]        wbOperandA,
    input  logic                                     commandValid,
    output logic                                     lightOut,
    output logic                                     ledOut,
    output logic                                     fanOut,
    output logic                                     timerStart,
    output logic                                     romSelect,
    output logic [homeCtrlPkg::soundAddrWidth-1:0]   soundAddress
);

    logic [homeCtrlPkg::aluOpWidth-1:0] aluOp;
    logic                               cmdValue;

    assign aluOp = wbInstruction[homeCtrlPkg::aluOpLsb +: homeCtrlPkg::aluOpWidth];
    // On or off level carried in the low bit
    assign cmdValue = wbInstruction[homeCtrlPkg::cmdBit];

    // Latches hold until the next matching command
    always_ff @(posedge clock) begin
        if (reset) begin
            lightOut <= 1'b0;
            ledOut <= 1'b0;
            fanOut <= 1'b0;
            timerStart <= 1'b0;
            romSelect <= 1'b0;
            soundAddress <= '0;
        end else if (commandValid) begin
            case (aluOp)
                homeCtrlPkg::cmdLight: lightOut <= cmdValue;
                homeCtrlPkg::cmdLed: ledOut <= cmdValue;
                homeCtrlPkg::cmdFan: fanOut <= cmdValue;
                homeCtrlPkg::cmdTimer: timerStart <= cmdValue;
                homeCtrlPkg::cmdRomSelect: romSelect <= cmdValue;
                // Sound address comes from register A
                homeCtrlPkg::cmdSoundAddr: begin
                    soundAddress <= wbOperandA[homeCtrlPkg::soundAddrWidth-1:0];
                end
                default: ;
            endcase
        end
    end

    // Non R-type words leave every actuator alone
    assert property (@(posedge clock) disable iff (reset)
        !commandValid |=> $stable({lightOut, ledOut, fanOut, timerStart, romSelect,
                                   soundAddress}));

endmodule

`default_nettype wire

// File: hw/countdownTimer.sv
`default_nettype none

module countdownTimer #(
    parameter int ticksPerStep = 50_000_000
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [3:0]                           timerSetting,
    input  logic                                 timerStart,
    output logic [homeCtrlPkg::timerWidth-1:0]   timerCount
);

    localparam int tickWidth = (ticksPerStep > 1) ? $clog2(ticksPerStep) : 1;
    // Largest four-bit setting times the scale
    localparam int maxCount = 15 * homeCtrlPkg::timerScale;

    logic [tickWidth-1:0] tickCounter;
    logic                 tick;

    assign tick = (tickCounter == tickWidth'(ticksPerStep - 1));

    // Free-running step divider
    always_ff @(posedge clock) begin
        if (reset || tick) begin
            tickCounter <= '0;
        end else begin
            tickCounter <= tickCounter + 1'b1;
        end
    end

    // Idle loads the setting, running counts down and stops at zero
    always_ff @(posedge clock) begin
        if (reset) begin
            timerCount <= '0;
        end else if (!timerStart) begin
            timerCount <= homeCtrlPkg::timerWidth'(timerSetting) * homeCtrlPkg::timerScale;
        end else if (tick && (timerCount != '0)) begin
            timerCount <= timerCount - 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        timerCount <= homeCtrlPkg::timerWidth'(maxCount));

endmodule

`default_nettype wire

// File: hw/homeCtrlCore.sv
`default_nettype none

module homeCtrlCore #(
    parameter int ticksPerStep = 50_000_000
) (
    input  logic                                     clock,
    input  logic                                     reset,
    // From the memory stage
    input  logic [homeCtrlPkg::wordWidth-1:0]        instruction,
    input  logic [homeCtrlPkg::wordWidth-1:0]        aluResult,
    input  logic [homeCtrlPkg::pcWidth-1:0]          pcPlusOne,
    input  logic [homeCtrlPkg::wordWidth-1:0]        memData,
    input  logic [homeCtrlPkg::wordWidth-1:0]        operandA,
    input  logic                                     overflow,
    // Switches and sensors
    input  logic                                     lightSwitch,
    input  logic                                     ledSwitch,
    input  logic                                     fanSwitch,
    input  logic                                     timerSwitch,
    input  logic [6:0]                               humidity,
    input  logic [4:0]                               temperature,
    input  logic                                     ambient,
    input  logic                                     speak,
    input  logic [3:0]                               timerSetting,
    // Register file write port
    output logic                                     regWriteEnable,
    output logic [homeCtrlPkg::regAddrWidth-1:0]     regWriteAddr,
    output logic [homeCtrlPkg::wordWidth-1:0]        regWriteData,
    // Relays, timer and sound
    output logic                                     lightOut,
    output logic                                     ledOut,
    output logic                                     fanOut,
    output logic [homeCtrlPkg::timerWidth-1:0]       timerCount,
    output logic                                     romSelect,
    output logic [homeCtrlPkg::soundAddrWidth-1:0]   soundAddress
);

    logic lightSwitchReg, ledSwitchReg, fanSwitchReg, timerSwitchReg;
    logic ambientReg, speakReg;
    logic [6:0] humidityReg;
    logic [4:0] temperatureReg;
    logic [3:0] tensDigit, onesDigit;
    logic [homeCtrlPkg::wordWidth-1:0] wbInstruction, wbOperandA;
    logic commandValid, timerStart;

    sensorPort i_sensorPort (
        .clock(clock), .reset(reset),
        .lightSwitch(lightSwitch), .ledSwitch(ledSwitch),
        .fanSwitch(fanSwitch), .timerSwitch(timerSwitch),
        .humidity(humidity), .temperature(temperature),
        .ambient(ambient), .speak(speak),
        .lightSwitchReg(lightSwitchReg), .ledSwitchReg(ledSwitchReg),
        .fanSwitchReg(fanSwitchReg), .timerSwitchReg(timerSwitchReg),
        .humidityReg(humidityReg), .temperatureReg(temperatureReg),
        .ambientReg(ambientReg), .speakReg(speakReg),
        .tensDigit(tensDigit), .onesDigit(onesDigit)
    );

    writebackDecode i_writebackDecode (
        .clock(clock), .reset(reset),
        .instruction(instruction), .aluResult(aluResult),
        .pcPlusOne(pcPlusOne), .memData(memData),
        .operandA(operandA), .overflow(overflow),
        .lightSwitchReg(lightSwitchReg), .ledSwitchReg(ledSwitchReg),
        .fanSwitchReg(fanSwitchReg), .timerSwitchReg(timerSwitchReg),
        .humidityReg(humidityReg), .temperatureReg(temperatureReg),
        .ambientReg(ambientReg), .speakReg(speakReg),
        .tensDigit(tensDigit), .onesDigit(onesDigit),
        .regWriteEnable(regWriteEnable), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .wbInstruction(wbInstruction),
        .wbOperandA(wbOperandA), .commandValid(commandValid)
    );

    actuatorControl i_actuatorControl (
        .clock(clock), .reset(reset),
        .wbInstruction(wbInstruction), .wbOperandA(wbOperandA),
        .commandValid(commandValid),
        .lightOut(lightOut), .ledOut(ledOut), .fanOut(fanOut),
        .timerStart(timerStart), .romSelect(romSelect),
        .soundAddress(soundAddress)
    );

    // Step length set here, short in simulation
    countdownTimer #(
        .ticksPerStep(ticksPerStep)
    ) i_countdownTimer (
        .clock(clock), .reset(reset),
        .timerSetting(timerSetting), .timerStart(timerStart),
        .timerCount(timerCount)
    );

endmodule

`default_nettype wire

// File: hw/homeCtrlPkg.sv
`default_nettype none

package homeCtrlPkg;

    // Datapath widths
    localparam int wordWidth = 32;
    localparam int pcWidth = 12;
    localparam int regAddrWidth = 5;
    localparam int opcodeWidth = 5;
    localparam int aluOpWidth = 5;
    localparam int soundAddrWidth = 16;
    localparam int timerWidth = 8;

    // Instruction field positions
    localparam int opcodeLsb = 27;
    localparam int rdLsb = 22;
    localparam int targetWidth = 27;
    localparam int aluOpLsb = 2;
    localparam int cmdBit = 0;

    // Opcodes seen at writeback
    localparam logic [opcodeWidth-1:0] opRtype = 5'b00000;
    localparam logic [opcodeWidth-1:0] opJal = 5'b00011;
    localparam logic [opcodeWidth-1:0] opAddi = 5'b00101;
    localparam logic [opcodeWidth-1:0] opLw = 5'b01000;
    localparam logic [opcodeWidth-1:0] opSetx = 5'b10101;

    // Arithmetic ALU ops that can overflow
    localparam logic [aluOpWidth-1:0] aluAdd = 5'b00000;
    localparam logic [aluOpWidth-1:0] aluSub = 5'b00001;
    localparam logic [aluOpWidth-1:0] aluMul = 5'b00110;
    localparam logic [aluOpWidth-1:0] aluDiv = 5'b00111;

    // Sensor read ops, result goes to rd
    localparam logic [aluOpWidth-1:0] rdLight = 5'b01000;
    localparam logic [aluOpWidth-1:0] rdLed = 5'b01001;
    localparam logic [aluOpWidth-1:0] rdFan = 5'b01010;
    localparam logic [aluOpWidth-1:0] rdHumidity = 5'b01011;
    localparam logic [aluOpWidth-1:0] rdTemp = 5'b01100;
    localparam logic [aluOpWidth-1:0] rdTimerSwitch = 5'b01101;
    localparam logic [aluOpWidth-1:0] rdAmbient = 5'b10100;
    localparam logic [aluOpWidth-1:0] rdSpeak = 5'b10101;
    localparam logic [aluOpWidth-1:0] rdDigit = 5'b11000;

    // Actuator command ops, no register write
    localparam logic [aluOpWidth-1:0] cmdLight = 5'b10000;
    localparam logic [aluOpWidth-1:0] cmdLed = 5'b10001;
    localparam logic [aluOpWidth-1:0] cmdFan = 5'b10010;
    localparam logic [aluOpWidth-1:0] cmdTimer = 5'b10011;
    localparam logic [aluOpWidth-1:0] cmdRomSelect = 5'b10110;
    localparam logic [aluOpWidth-1:0] cmdSoundAddr = 5'b10111;

    // Fixed destinations
    localparam logic [regAddrWidth-1:0] regLink = 5'd31;
    localparam logic [regAddrWidth-1:0] regStatus = 5'd30;

    // Codes written on overflow
    localparam logic [wordWidth-1:0] ovfAdd = 32'd1;
    localparam logic [wordWidth-1:0] ovfAddi = 32'd2;
    localparam logic [wordWidth-1:0] ovfSub = 32'd3;
    localparam logic [wordWidth-1:0] ovfMul = 32'd4;
    localparam logic [wordWidth-1:0] ovfDiv = 32'd5;

    // Seconds per timer unit
    localparam logic [timerWidth-1:0] timerScale = 8'd5;

endpackage

`default_nettype wire

// File: hw/sensorPort.sv
`default_nettype none

module sensorPort (
    input  logic       clock,
    input  logic       reset,
    input  logic       lightSwitch,
    input  logic       ledSwitch,
    input  logic       fanSwitch,
    input  logic       timerSwitch,
    input  logic [6:0] humidity,
    input  logic [4:0] temperature,
    input  logic       ambient,
    input  logic       speak,
    output logic       lightSwitchReg,
    output logic       ledSwitchReg,
    output logic       fanSwitchReg,
    output logic       timerSwitchReg,
    output logic [6:0] humidityReg,
    output logic [4:0] temperatureReg,
    output logic       ambientReg,
    output logic       speakReg,
    output logic [3:0] tensDigit,
    output logic [3:0] onesDigit
);

    // Tens in upper nibble, ones in lower
    logic [7:0] bcd;

    // Shift-and-add-three over the five temperature bits
    always_comb begin
        bcd = '0;
        for (int i = 4; i >= 0; i--) begin
            if (bcd[3:0] > 4'd4) begin
                bcd[3:0] = bcd[3:0] + 4'd3;
            end
            if (bcd[7:4] > 4'd4) begin
                bcd[7:4] = bcd[7:4] + 4'd3;
            end
            bcd = {bcd[6:0], temperatureReg[i]};
        end
    end

    // Sensor levels first, digits one edge behind
    always_ff @(posedge clock) begin
        if (reset) begin
            lightSwitchReg <= 1'b0;
            ledSwitchReg <= 1'b0;
            fanSwitchReg <= 1'b0;
            timerSwitchReg <= 1'b0;
            humidityReg <= '0;
            temperatureReg <= '0;
            ambientReg <= 1'b0;
            speakReg <= 1'b0;
            tensDigit <= '0;
            onesDigit <= '0;
        end else begin
            lightSwitchReg <= lightSwitch;
            ledSwitchReg <= ledSwitch;
            fanSwitchReg <= fanSwitch;
            timerSwitchReg <= timerSwitch;
            humidityReg <= humidity;
            temperatureReg <= temperature;
            ambientReg <= ambient;
            speakReg <= speak;
            tensDigit <= bcd[7:4];
            onesDigit <= bcd[3:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/writebackDecode.sv
`default_nettype none

module writebackDecode (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [homeCtrlPkg::wordWidth-1:0]      instruction,
    input  logic [homeCtrlPkg::wordWidth-1:0]      aluResult,
    input  logic [homeCtrlPkg::pcWidth-1:0]        pcPlusOne,
    input  logic [homeCtrlPkg::wordWidth-1:0]      memData,
    input  logic [homeCtrlPkg::wordWidth-1:0]      operandA,
    input  logic                                   overflow,
    input  logic                                   lightSwitchReg,
    input  logic                                   ledSwitchReg,
    input  logic                                   fanSwitchReg,
    input  logic                                   timerSwitchReg,
    input  logic [6:0]                             humidityReg,
    input  logic [4:0]                             temperatureReg,
    input  logic                                   ambientReg,
    input  logic                                   speakReg,
    input  logic [3:0]                             tensDigit,
    input  logic [3:0]                             onesDigit,
    output logic                                   regWriteEnable,
    output logic [homeCtrlPkg::regAddrWidth-1:0]   regWriteAddr,
    output logic [homeCtrlPkg::wordWidth-1:0]      regWriteData,
    output logic [homeCtrlPkg::wordWidth-1:0]      wbInstruction,
    output logic [homeCtrlPkg::wordWidth-1:0]      wbOperandA,
    output logic                                   commandValid
);

    logic [homeCtrlPkg::wordWidth-1:0]   wbAluResult;
    logic [homeCtrlPkg::pcWidth-1:0]     wbPcPlusOne;
    logic [homeCtrlPkg::wordWidth-1:0]   wbMemData;
    logic                                wbOverflow;
    logic [homeCtrlPkg::opcodeWidth-1:0] opcode;
    logic [homeCtrlPkg::aluOpWidth-1:0]  aluOp;
    logic isRtype, isJal, isAddi, isLw, isSetx;
    logic isArith, isReadOp;
    logic selJal, selAlu, selSetx, selLw, selSensor, selOvf;
    logic [homeCtrlPkg::wordWidth-1:0]   sensorWord;
    logic [homeCtrlPkg::wordWidth-1:0]   ovfCode;

    // Writeback register, cleared to an R-type add of zero
    always_ff @(posedge clock) begin
        if (reset) begin
            wbInstruction <= '0;
            wbAluResult <= '0;
            wbPcPlusOne <= '0;
            wbMemData <= '0;
            wbOperandA <= '0;
            wbOverflow <= 1'b0;
        end else begin
            wbInstruction <= instruction;
            wbAluResult <= aluResult;
            wbPcPlusOne <= pcPlusOne;
            wbMemData <= memData;
            wbOperandA <= operandA;
            wbOverflow <= overflow;
        end
    end

    assign opcode = wbInstruction[homeCtrlPkg::opcodeLsb +: homeCtrlPkg::opcodeWidth];
    assign aluOp = wbInstruction[homeCtrlPkg::aluOpLsb +: homeCtrlPkg::aluOpWidth];

    assign isRtype = (opcode == homeCtrlPkg::opRtype);
    assign isJal = (opcode == homeCtrlPkg::opJal);
    assign isAddi = (opcode == homeCtrlPkg::opAddi);
    assign isLw = (opcode == homeCtrlPkg::opLw);
    assign isSetx = (opcode == homeCtrlPkg::opSetx);

    // Plain ALU ops sit in the 00xxx range
    assign isArith = isRtype && (aluOp[4:3] == 2'b00);
    assign isReadOp = isRtype && (aluOp inside {homeCtrlPkg::rdLight, homeCtrlPkg::rdLed,
        homeCtrlPkg::rdFan, homeCtrlPkg::rdHumidity, homeCtrlPkg::rdTemp,
        homeCtrlPkg::rdTimerSwitch, homeCtrlPkg::rdAmbient, homeCtrlPkg::rdSpeak,
        homeCtrlPkg::rdDigit});

    // Actuator commands only come from R-type words
    assign commandValid = isRtype;

    assign regWriteEnable = isJal || isAddi || isLw || isSetx || isArith || isReadOp;

    always_comb begin
        if (isSetx) begin
            regWriteAddr = homeCtrlPkg::regStatus;
        end else if (isJal) begin
            regWriteAddr = homeCtrlPkg::regLink;
        end else begin
            regWriteAddr = wbInstruction[homeCtrlPkg::rdLsb +: homeCtrlPkg::regAddrWidth];
        end
    end

    // Sensor value for the read op, zero-extended
    always_comb begin
        sensorWord = '0;
        case (aluOp)
            homeCtrlPkg::rdLight: sensorWord[0] = lightSwitchReg;
            homeCtrlPkg::rdLed: sensorWord[0] = ledSwitchReg;
            homeCtrlPkg::rdFan: sensorWord[0] = fanSwitchReg;
            homeCtrlPkg::rdTimerSwitch: sensorWord[0] = timerSwitchReg;
            homeCtrlPkg::rdHumidity: sensorWord[6:0] = humidityReg;
            homeCtrlPkg::rdTemp: sensorWord[4:0] = temperatureReg;
            homeCtrlPkg::rdAmbient: sensorWord[0] = ambientReg;
            homeCtrlPkg::rdSpeak: sensorWord[0] = speakReg;
            // Bit 0 picks tens over ones
            homeCtrlPkg::rdDigit: begin
                sensorWord[3:0] = wbInstruction[homeCtrlPkg::cmdBit] ? tensDigit : onesDigit;
            end
            default: sensorWord = '0;
        endcase
    end

    // Zero means the op has no overflow code
    always_comb begin
        ovfCode = '0;
        if (isAddi) begin
            ovfCode = homeCtrlPkg::ovfAddi;
        end else if (isRtype) begin
            case (aluOp)
                homeCtrlPkg::aluAdd: ovfCode = homeCtrlPkg::ovfAdd;
                homeCtrlPkg::aluSub: ovfCode = homeCtrlPkg::ovfSub;
                homeCtrlPkg::aluMul: ovfCode = homeCtrlPkg::ovfMul;
                homeCtrlPkg::aluDiv: ovfCode = homeCtrlPkg::ovfDiv;
                default: ovfCode = '0;
            endcase
        end
    end

    // Exclusive data sources
    assign selJal = isJal;
    assign selAlu = (isArith || isAddi) && !wbOverflow;
    assign selSetx = isSetx;
    assign selLw = isLw;
    assign selSensor = isReadOp;
    assign selOvf = wbOverflow && (ovfCode != '0);

    // AND-OR select, nothing selected gives zero
    assign regWriteData =
        ({homeCtrlPkg::wordWidth{selJal}} &
            {{(homeCtrlPkg::wordWidth - homeCtrlPkg::pcWidth){1'b0}}, wbPcPlusOne}) |
        ({homeCtrlPkg::wordWidth{selAlu}} & wbAluResult) |
        ({homeCtrlPkg::wordWidth{selSetx}} &
            {{(homeCtrlPkg::wordWidth - homeCtrlPkg::targetWidth){1'b0}},
             wbInstruction[homeCtrlPkg::targetWidth-1:0]}) |
        ({homeCtrlPkg::wordWidth{selLw}} & wbMemData) |
        ({homeCtrlPkg::wordWidth{selSensor}} & sensorWord) |
        ({homeCtrlPkg::wordWidth{selOvf}} & ovfCode);

    // Two sources at once would OR their data together
    assert property (@(posedge clock) disable iff (reset)
        $onehot0({selJal, selAlu, selSetx, selLw, selSensor, selOvf}));

endmodule

`default_nettype wire

// File: project.f
hw/homeCtrlPkg.sv
hw/sensorPort.sv
hw/writebackDecode.sv
hw/actuatorControl.sv
hw/countdownTimer.sv
hw/homeCtrlCore.sv
test/homeCtrlChecker.sv
test/homeCtrlTb.sv

// File: run.sh
#!/bin/sh
# Build and run the home controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module homeCtrlTb -f project.f -o homeCtrlSim

./obj_dir/homeCtrlSim | tee sim.log

# Pass only if the testbench printed the pass line
grep -q "^TEST RESULT: PASS$" sim.log

// File: test/homeCtrlCases.txt
// instr aluRes pc+1 memData opA ovf | light led fan timerSw humidity temp ambient speak
// expected | wrEn wrAddr wrData light led fan romSel soundAddr
00c00000 1234abcd 000 0 0 0 1 0 1 1 2d 17 0 1 1 03 1234abcd 0 0 0 0 0000
01400004 fffffff0 000 0 0 0 1 0 1 1 2d 17 0 1 1 05 fffffff0 0 0 0 0 0000
29c00000 00000064 000 0 0 0 1 0 1 1 2d 17 0 1 1 07 00000064 0 0 0 0 0000
42400000 11111111 000 cafef00d 0 0 1 0 1 1 2d 17 0 1 1 09 cafef00d 0 0 0 0 0000
18000123 55555555 3a7 0 0 0 1 0 1 1 2d 17 0 1 1 1f 000003a7 0 0 0 0 0000
ada5a5a5 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 1e 05a5a5a5 0 0 0 0 0000
00800000 7fffffff 000 0 0 1 1 0 1 1 2d 17 0 1 1 02 00000001 0 0 0 0 0000
29000000 80000000 000 0 0 1 1 0 1 1 2d 17 0 1 1 04 00000002 0 0 0 0 0000
01800004 80000001 000 0 0 1 1 0 1 1 2d 17 0 1 1 06 00000003 0 0 0 0 0000
02000018 40000000 000 0 0 1 1 0 1 1 2d 17 0 1 1 08 00000004 0 0 0 0 0000
0280001c 00000000 000 0 0 1 1 0 1 1 2d 17 0 1 1 0a 00000005 0 0 0 0 0000
02c00020 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 0b 00000001 0 0 0 0 0000
03000024 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 0c 00000000 0 0 0 0 0000
03400028 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 0d 00000001 0 0 0 0 0000
0380002c 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 0e 0000002d 0 0 0 0 0000
03c00030 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 0f 00000017 0 0 0 0 0000
04000034 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 10 00000001 0 0 0 0 0000
04400050 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 11 00000000 0 0 0 0 0000
04800054 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 12 00000001 0 0 0 0 0000
04c00061 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 13 00000002 0 0 0 0 0000
04c00060 0 000 0 0 0 1 0 1 1 2d 17 0 1 1 13 00000003 0 0 0 0 0000
02c00020 0 000 0 0 0 0 1 0 0 63 1f 1 0 1 0b 00000000 0 0 0 0 0000
0380002c 0 000 0 0 0 0 1 0 0 63 1f 1 0 1 0e 00000063 0 0 0 0 0000
04c00061 0 000 0 0 0 0 1 0 0 63 1f 1 0 1 13 00000003 0 0 0 0 0000
04c00060 0 000 0 0 0 0 1 0 0 63 1f 1 0 1 13 00000001 0 0 0 0 0000
04400050 0 000 0 0 0 0 1 0 0 63 1f 1 0 1 11 00000001 0 0 0 0 0000
00000041 deadbeef 000 0 0 0 1 0 1 1 2d 17 0 1 0 00 00000000 1 0 0 0 0000
00000045 deadbeef 000 0 0 0 1 0 1 1 2d 17 0 1 0 00 00000000 1 1 0 0 0000
00000049 deadbeef 000 0 0 0 1 0 1 1 2d 17 0 1 0 00 00000000 1 1 1 0 0000
00000059 deadbeef 000 0 0 0 1 0 1 1 2d 17 0 1 0 00 00000000 1 1 1 1 0000
0000005c deadbeef 000 0 0001beef 0 1 0 1 1 2d 17 0 1 0 00 00000000 1 1 1 1 beef
00000040 deadbeef 000 0 0 0 1 0 1 1 2d 17 0 1 0 00 00000000 0 1 1 1 beef
00000048 deadbeef 000 0 0 0 1 0 1 1 2d 17 0 1 0 00 00000000 0 1 0 1 beef

// File: test/homeCtrlChecker.sv
`default_nettype none

module homeCtrlChecker (
    input  logic                                   clock,
    input  int                                     caseId,
    // Expected register write and actuator state
    input  logic                                   checkStrobe,
    input  logic                                   expWriteEnable,
    input  logic [homeCtrlPkg::regAddrWidth-1:0]   expWriteAddr,
    input  logic [homeCtrlPkg::wordWidth-1:0]      expWriteData,
    input  logic                                   expLight,
    input  logic                                   expLed,
    input  logic                                   expFan,
    input  logic                                   expRom,
    input  logic [homeCtrlPkg::soundAddrWidth-1:0] expSound,
    // Timer checks
    input  logic                                   timerStrobe,
    input  logic [homeCtrlPkg::timerWidth-1:0]     expTimerCount,
    input  logic                                   timerWatch,
    // DUT outputs
    input  logic                                   regWriteEnable,
    input  logic [homeCtrlPkg::regAddrWidth-1:0]   regWriteAddr,
    input  logic [homeCtrlPkg::wordWidth-1:0]      regWriteData,
    input  logic                                   lightOut,
    input  logic                                   ledOut,
    input  logic                                   fanOut,
    input  logic                                   romSelect,
    input  logic [homeCtrlPkg::soundAddrWidth-1:0] soundAddress,
    input  logic [homeCtrlPkg::timerWidth-1:0]     timerCount,
    output int                                     checkCount,
    output int                                     errorCount
);

    logic [homeCtrlPkg::timerWidth-1:0] lastCount;
    logic                               watchPrimed;

    initial begin
        checkCount = 0;
        errorCount = 0;
        lastCount = '0;
        watchPrimed = 1'b0;
    end

    // One field compare, reports on mismatch
    task automatic compareField(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Sample away from the driving edge
    always @(negedge clock) begin
        if (checkStrobe) begin
            compareField($sformatf("case %0d regWriteEnable", caseId),
                         32'(regWriteEnable), 32'(expWriteEnable));
            compareField($sformatf("case %0d regWriteAddr", caseId),
                         32'(regWriteAddr), 32'(expWriteAddr));
            compareField($sformatf("case %0d regWriteData", caseId), regWriteData, expWriteData);
            compareField($sformatf("case %0d lightOut", caseId), 32'(lightOut), 32'(expLight));
            compareField($sformatf("case %0d ledOut", caseId), 32'(ledOut), 32'(expLed));
            compareField($sformatf("case %0d fanOut", caseId), 32'(fanOut), 32'(expFan));
            compareField($sformatf("case %0d romSelect", caseId), 32'(romSelect), 32'(expRom));
            compareField($sformatf("case %0d soundAddress", caseId),
                         32'(soundAddress), 32'(expSound));
        end
        if (timerStrobe) begin
            compareField("idle timerCount", 32'(timerCount), 32'(expTimerCount));
        end
        // A running countdown must never go up
        if (timerWatch) begin
            if (watchPrimed && (timerCount > lastCount)) begin
                errorCount++;
                $display("FAILED at time %0t: timerCount rose from %0d to %0d",
                         $time, lastCount, timerCount);
            end
            lastCount <= timerCount;
            watchPrimed <= 1'b1;
        end else begin
            watchPrimed <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: test/homeCtrlTb.sv
`default_nettype none

module homeCtrlTb;

    localparam int ticksPerStep = 8;
    localparam int fieldsPerCase = 22;
    localparam int numCases = 33;
    // Countdown start value used by the running test
    localparam logic [3:0] runSetting = 4'd3;
    // Three units of five seconds each
    localparam logic [homeCtrlPkg::timerWidth-1:0] runStartCount = 8'd15;

    logic clock;
    logic reset;
    logic [homeCtrlPkg::wordWidth-1:0] instruction, aluResult, memData, operandA;
    logic [homeCtrlPkg::pcWidth-1:0] pcPlusOne;
    logic overflow;
    logic lightSwitch, ledSwitch, fanSwitch, timerSwitch, ambient, speak;
    logic [6:0] humidity;
    logic [4:0] temperature;
    logic [3:0] timerSetting;
    logic regWriteEnable, lightOut, ledOut, fanOut, romSelect;
    logic [homeCtrlPkg::regAddrWidth-1:0] regWriteAddr;
    logic [homeCtrlPkg::wordWidth-1:0] regWriteData;
    logic [homeCtrlPkg::timerWidth-1:0] timerCount;
    logic [homeCtrlPkg::soundAddrWidth-1:0] soundAddress;

    // Expected values handed to the checker
    logic checkStrobe, timerStrobe, timerWatch;
    logic expWriteEnable, expLight, expLed, expFan, expRom;
    logic [homeCtrlPkg::regAddrWidth-1:0] expWriteAddr;
    logic [homeCtrlPkg::wordWidth-1:0] expWriteData;
    logic [homeCtrlPkg::soundAddrWidth-1:0] expSound;
    logic [homeCtrlPkg::timerWidth-1:0] expTimerCount;
    int caseId;
    int checkCount, errorCount, timeoutCount;

    logic [31:0] caseMem [0:numCases*fieldsPerCase-1];

    always #5 clock = ~clock;

    homeCtrlCore #(.ticksPerStep(ticksPerStep)) i_homeCtrlCore (
        .clock(clock), .reset(reset),
        .instruction(instruction), .aluResult(aluResult), .pcPlusOne(pcPlusOne),
        .memData(memData), .operandA(operandA), .overflow(overflow),
        .lightSwitch(lightSwitch), .ledSwitch(ledSwitch), .fanSwitch(fanSwitch),
        .timerSwitch(timerSwitch), .humidity(humidity), .temperature(temperature),
        .ambient(ambient), .speak(speak), .timerSetting(timerSetting),
        .regWriteEnable(regWriteEnable), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .lightOut(lightOut), .ledOut(ledOut),
        .fanOut(fanOut), .timerCount(timerCount), .romSelect(romSelect),
        .soundAddress(soundAddress)
    );

    homeCtrlChecker i_homeCtrlChecker (
        .clock(clock), .caseId(caseId), .checkStrobe(checkStrobe),
        .expWriteEnable(expWriteEnable), .expWriteAddr(expWriteAddr),
        .expWriteData(expWriteData), .expLight(expLight), .expLed(expLed),
        .expFan(expFan), .expRom(expRom), .expSound(expSound),
        .timerStrobe(timerStrobe), .expTimerCount(expTimerCount), .timerWatch(timerWatch),
        .regWriteEnable(regWriteEnable), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .lightOut(lightOut), .ledOut(ledOut),
        .fanOut(fanOut), .romSelect(romSelect), .soundAddress(soundAddress),
        .timerCount(timerCount), .checkCount(checkCount), .errorCount(errorCount)
    );

    // Drive one line of the cases file, hold three cycles, then strobe the checker
    task automatic applyCase(input int idx);
        int base;
        base = idx * fieldsPerCase;
        @(posedge clock);
        caseId <= idx;
        instruction <= caseMem[base];
        aluResult <= caseMem[base+1];
        pcPlusOne <= caseMem[base+2][homeCtrlPkg::pcWidth-1:0];
        memData <= caseMem[base+3];
        operandA <= caseMem[base+4];
        overflow <= caseMem[base+5][0];
        lightSwitch <= caseMem[base+6][0];
        ledSwitch <= caseMem[base+7][0];
        fanSwitch <= caseMem[base+8][0];
        timerSwitch <= caseMem[base+9][0];
        humidity <= caseMem[base+10][6:0];
        temperature <= caseMem[base+11][4:0];
        ambient <= caseMem[base+12][0];
        speak <= caseMem[base+13][0];
        expWriteEnable <= caseMem[base+14][0];
        expWriteAddr <= caseMem[base+15][homeCtrlPkg::regAddrWidth-1:0];
        expWriteData <= caseMem[base+16];
        expLight <= caseMem[base+17][0];
        expLed <= caseMem[base+18][0];
        expFan <= caseMem[base+19][0];
        expRom <= caseMem[base+20][0];
        expSound <= caseMem[base+21][homeCtrlPkg::soundAddrWidth-1:0];
        repeat (3) @(posedge clock);
        checkStrobe <= 1'b1;
        @(posedge clock);
        checkStrobe <= 1'b0;
    endtask

    // Idle timer shows the setting times five
    task automatic checkIdleTimer(input logic [3:0] setting,
                                  input logic [homeCtrlPkg::timerWidth-1:0] expectedCount);
        @(posedge clock);
        instruction <= '0;
        timerSetting <= setting;
        repeat (2) @(posedge clock);
        expTimerCount <= expectedCount;
        timerStrobe <= 1'b1;
        @(posedge clock);
        timerStrobe <= 1'b0;
    endtask

    // Start the countdown and wait for zero
    task automatic runCountdown();
        int limit;
        int waited;
        bit reached;
        limit = 16 * ticksPerStep * int'(runStartCount);
        reached = 1'b0;
        @(posedge clock);
        // cmdTimer with bit 0 set
        instruction <= 32'h0000_004d;
        timerWatch <= 1'b1;
        @(posedge clock);
        instruction <= '0;
        for (waited = 0; (waited < limit) && !reached; waited++) begin
            @(negedge clock);
            if (timerCount == '0) begin
                reached = 1'b1;
            end
        end
        if (!reached) begin
            timeoutCount++;
            $display("Timeout: timerCount did not reach zero within %0d cycles", limit);
        end
        repeat (4) @(posedge clock);
        timerWatch <= 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        instruction = '0;
        aluResult = '0;
        pcPlusOne = '0;
        memData = '0;
        operandA = '0;
        overflow = 1'b0;
        {lightSwitch, ledSwitch, fanSwitch, timerSwitch, ambient, speak} = '0;
        humidity = '0;
        temperature = '0;
        timerSetting = '0;
        checkStrobe = 1'b0;
        timerStrobe = 1'b0;
        timerWatch = 1'b0;
        {expWriteEnable, expLight, expLed, expFan, expRom} = '0;
        expWriteAddr = '0;
        expWriteData = '0;
        expSound = '0;
        expTimerCount = '0;
        caseId = 0;
        timeoutCount = 0;
        $readmemh("test/homeCtrlCases.txt", caseMem);

        repeat (16) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < numCases; i++) begin
            applyCase(i);
        end

        // Fifteen units of five seconds each
        checkIdleTimer(4'hf, 8'd75);
        checkIdleTimer(runSetting, runStartCount);
        runCountdown();

        repeat (2) @(negedge clock);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
        if ((errorCount == 0) && (timeoutCount == 0) && (checkCount > 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
